// File: project.f
verilog/demux_pkg.sv
verilog/tag_demux.sv
verilog/channel_fifo.sv
verilog/tagged_demux_fifo.sv
tb/tb_tagged_demux_fifo.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

TOP=tb_tagged_demux_fifo
OBJ=obj_dir

verilator --binary --timing --assert -sv -f project.f \
   --top-module "$TOP" -Mdir "$OBJ" -o sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$("./$OBJ/sim")
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
   exit 0
fi

echo "pass message not found in the simulation output"
exit 1

// File: tb/demux_stimulus.txt
# P <tag> <data in hex> : push one word, held by the source until taken
# D <pull mask, ch4 down to ch0> <cycles> : set the receivers, then run idle cycles
# E <count> : drop count expected once the pending word is taken
# routing and order with every buffered receiver pulling
D 10111 1
P 0 a001
P 1 b001
P 2 c001
P 4 e001
P 0 a002
P 2 c002
P 4 e002
P 1 b002
D 10111 4
# back-pressure on channel 1 with its receiver off
D 00000 1
P 1 b101
P 1 b102
P 1 b103
P 1 b104
P 1 b105
D 00000 6
D 00010 8
# bypass channel words leave at once, yumi_i[3] stays low
P 3 3001
P 0 a101
P 3 3002
P 3 3003
# tags 5 to 7 are taken and counted
P 5 dead
P 6 beef
P 3 3004
P 7 0bad
P 7 f00d
E 4
# channel 0 drains while channel 2 fills
D 00001 0
P 0 a201
P 0 a202
P 2 c201
P 0 a203
P 2 c202
D 00101 8
P 6 1234
E 5
D 10111 4

// File: tb/tb_tagged_demux_fifo.sv
//####################################################################
// replays tb/demux_stimulus.txt and checks every channel each cycle
// against a queue model, receivers pull only where the mask allows
//####################################################################
`timescale 1ns/1ps

module tb_tagged_demux_fifo
   import demux_pkg::*;
();

   localparam int    RESET_CYCLES = 16;
   localparam int    SEED         = 13080;
   localparam string STIM_FILE    = "tb/demux_stimulus.txt";

   logic                     clk;
   logic                     arst_n;
   logic                     in_v;
   tag_t                     in_tag;
   data_t                    in_data;
   logic                     in_yumi;
   logic  [NUM_CH-1:0]       out_v;
   data_t [NUM_CH-1:0]       out_data;
   logic  [NUM_CH-1:0]       out_yumi;
   drop_cnt_t                drop_cnt;

   // queue model and the word the source is holding
   data_t             model_q [NUM_CH][$];
   logic [NUM_CH-1:0] drain_mask;
   logic              pend;
   tag_t              pend_tag;
   data_t             pend_data;
   drop_cnt_t         drops_exp;
   int                err_cnt = 0;
   int                n_rec = 0;
   string             rec_kind [$];
   int                rec_a [$];
   int                rec_b [$];

   tagged_demux_fifo u_tagged_demux_fifo
   (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .v_i        (in_v),
      .tag_i      (in_tag),
      .data_i     (in_data),
      .yumi_o     (in_yumi),
      .v_o        (out_v),
      .data_o     (out_data),
      .yumi_i     (out_yumi),
      .drop_cnt_o (drop_cnt)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic fail_run();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_data(input data_t got, input data_t exp, input int ch);
      if (got !== exp)
      begin
         err_cnt++;
         $display("Mismatch at %0t: data_o[%0d] is %h, expected %h", $time, ch, got, exp);
         fail_run();
      end
   endtask

   task automatic check_valid(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("Mismatch at %0t: v_o is %b, expected %b", $time, got, exp);
         fail_run();
      end
   endtask

   task automatic check_yumi(input logic got, input logic exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("Mismatch at %0t: yumi_o is %b, expected %b", $time, got, exp);
         fail_run();
      end
   endtask

   task automatic check_drops(input drop_cnt_t got, input drop_cnt_t exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("Mismatch at %0t: drop_cnt_o is %0d, expected %0d", $time, got, exp);
         fail_run();
      end
   endtask

   // one clock cycle, entered 2 ns after a rising edge
   task automatic run_cycle();
      logic [NUM_CH-1:0] pull;
      logic [NUM_CH-1:0] exp_v;
      logic              exp_yumi;
      int                t;
      pull     = '0;
      exp_v    = '0;
      exp_yumi = 1'b0;
      t        = int'(pend_tag);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (CHAN_KIND[ch] == CHAN_BUFFERED && model_q[ch].size() > 0)
         begin
            exp_v[ch] = 1'b1;
            pull[ch]  = drain_mask[ch];
         end
      end
      if (pend)
      begin
         if (t >= NUM_CH)
            exp_yumi = 1'b1;
         else if (CHAN_KIND[t] == CHAN_BYPASS)
         begin
            exp_yumi = 1'b1;
            exp_v[t] = 1'b1;
         end
         else
            exp_yumi = (model_q[t].size() < FIFO_ELS);
      end
      in_v     = pend;
      in_tag   = pend_tag;
      in_data  = pend_data;
      out_yumi = pull;
      @(negedge clk);
      check_valid(out_v, exp_v);
      check_yumi(in_yumi, exp_yumi);
      check_drops(drop_cnt, drops_exp);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (exp_v[ch] && CHAN_KIND[ch] == CHAN_BYPASS)
            check_data(out_data[ch], pend_data, ch);
         else if (exp_v[ch])
            check_data(out_data[ch], model_q[ch][0], ch);
      end
      @(posedge clk);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (pull[ch])
            void'(model_q[ch].pop_front());
      end
      if (pend && exp_yumi)
      begin
         if (t >= NUM_CH && drops_exp != '1)
            drops_exp++;
         else if (t < NUM_CH && CHAN_KIND[t] == CHAN_BUFFERED)
            model_q[t].push_back(pend_data);
         pend = 1'b0;
      end
      #2;
   endtask

   // the source holds a word until it is taken, then idles a little
   task automatic push_word(input tag_t tag, input data_t data);
      int gap;
      while (pend)
         run_cycle();
      gap = $urandom % 3;
      repeat (gap) run_cycle();
      pend      = 1'b1;
      pend_tag  = tag;
      pend_data = data;
      run_cycle();
   endtask

   initial
   begin
      int    fd;
      int    n;
      int    a;
      int    b;
      string kind;
      string rest;
      arst_n     = 1'b0;
      in_v       = 1'b0;
      in_tag     = '0;
      in_data    = '0;
      out_yumi   = '0;
      pend       = 1'b0;
      pend_tag   = '0;
      pend_data  = '0;
      drain_mask = '0;
      drops_exp  = '0;
      void'($urandom(SEED));
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file %s", STIM_FILE);
         fail_run();
      end
      while ($fscanf(fd, "%s", kind) == 1)
      begin
         b = 0;
         if (kind.substr(0, 0) == "#")
            n = $fgets(rest, fd);
         else if (kind == "P" || kind == "D" || kind == "E")
         begin
            if (kind == "P")
               n = $fscanf(fd, "%h %h", a, b);
            else if (kind == "D")
               n = $fscanf(fd, "%b %d", a, b);
            else
               n = $fscanf(fd, "%d", a) + 1;
            if (n != 2)
            begin
               $display("record %0d of the stimulus file is malformed", rec_kind.size());
               fail_run();
            end
            rec_kind.push_back(kind);
            rec_a.push_back(a);
            rec_b.push_back(b);
         end
         else
         begin
            $display("unknown record kind %s in the stimulus file", kind);
            fail_run();
         end
      end
      $fclose(fd);
      n_rec = rec_kind.size();

      // outputs must be quiet while reset is held
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_valid(out_v, '0);
      check_drops(drop_cnt, '0);
      @(posedge clk);
      #2;
      arst_n = 1'b1;

      foreach (rec_kind[i])
      begin
         if (rec_kind[i] == "P")
            push_word(tag_t'(rec_a[i]), data_t'(rec_b[i]));
         else if (rec_kind[i] == "D")
         begin
            drain_mask = NUM_CH'(rec_a[i]);
            repeat (rec_b[i]) run_cycle();
         end
         else
         begin
            while (pend)
               run_cycle();
            check_drops(drop_cnt, drop_cnt_t'(rec_a[i]));
         end
      end
      while (pend)
         run_cycle();

      if (err_cnt == 0)
      begin
         $display("Result: PASSED");
         $finish;
      end
      else
         fail_run();
   end

   // the run is bounded by 50 cycles per stimulus record
   initial
   begin
      wait (n_rec > 0);
      repeat (RESET_CYCLES + 50 * n_rec) @(posedge clk);
      $display("timeout: the test did not finish within %0d cycles",
               RESET_CYCLES + 50 * n_rec);
      fail_run();
   end

endmodule

// File: verilog/channel_fifo.sv
//####################################################################
// register FIFO of FIFO_ELS words, valid/ready in and valid/yumi out.
// a read does not free space for a write until the next cycle
//####################################################################
`timescale 1ns/1ps

module channel_fifo import demux_pkg::*;
(
   input  logic  clk_i,
   input  logic  arst_n_i,

   // write side
   input  logic  v_i,
   input  data_t data_i,
   output logic  ready_o,

   // read side
   output logic  v_o,
   output data_t data_o,
   input  logic  yumi_i
);

   data_t            mem [FIFO_ELS];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [OCC_W-1:0] occ_q;
   logic             full;
   logic             empty;
   logic             wr_en;
   logic             rd_en;

   assign full  = (occ_q == OCC_W'(FIFO_ELS));
   assign empty = (occ_q == '0);

   // the demux only asserts valid while we are ready
   assign wr_en = v_i;
   assign rd_en = yumi_i;

   // payload storage
   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   // pointers wrap by compare so the depth need not be a power of two
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
      end
      else if (wr_en)
      begin
         if (wr_ptr_q == PTR_W'(FIFO_ELS - 1))
         begin
            wr_ptr_q <= '0;
         end
         else
         begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rd_ptr_q <= '0;
      end
      else if (rd_en)
      begin
         if (rd_ptr_q == PTR_W'(FIFO_ELS - 1))
         begin
            rd_ptr_q <= '0;
         end
         else
         begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // occupancy holds still when a write and a read meet
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         occ_q <= '0;
      end
      else if (wr_en && !rd_en)
      begin
         occ_q <= occ_q + 1'b1;
      end
      else if (rd_en && !wr_en)
      begin
         occ_q <= occ_q - 1'b1;
      end
   end

   assign ready_o = ~full;
   assign v_o     = ~empty;
   assign data_o  = mem[rd_ptr_q];

   a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      full |-> !v_i)
      else $error("channel_fifo written while full");

   a_no_underflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      empty |-> !yumi_i)
      else $error("channel_fifo dequeued while empty");

endmodule

// File: verilog/demux_pkg.sv
//####################################################################
// shared sizes and channel kinds for the tagged demux buffer.
// FIFO_ELS must be 2 or more, and tags at or above NUM_CH are dropped.
//####################################################################

package demux_pkg;

   // data path and tag sizes
   localparam int DATA_W   = 16;
   localparam int NUM_CH   = 5;
   localparam int TAG_W    = 3;

   // storage per buffered channel
   localparam int FIFO_ELS = 4;
   localparam int PTR_W    = $clog2(FIFO_ELS);
   localparam int OCC_W    = $clog2(FIFO_ELS + 1);

   // width of the saturating count of dropped words
   localparam int CNT_W    = 8;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [TAG_W-1:0]  tag_t;
   typedef logic [CNT_W-1:0]  drop_cnt_t;

   // a buffered channel owns a FIFO, a bypass channel has no storage
   // and its receiver must always be ready
   typedef enum logic
   {
      CHAN_BUFFERED = 1'b0,
      CHAN_BYPASS   = 1'b1
   } chan_kind_e;

   // one entry per channel, index 0 first
   // channel 3 carries the credit return traffic and is not stored
   localparam chan_kind_e CHAN_KIND [NUM_CH] = '{
      CHAN_BUFFERED,
      CHAN_BUFFERED,
      CHAN_BUFFERED,
      CHAN_BYPASS,
      CHAN_BUFFERED
   };

endpackage

// File: verilog/tag_demux.sv
//####################################################################
// steers the input valid to one channel by tag, fully combinational
// apart from the drop counter, which saturates at its top value
//####################################################################
`timescale 1ns/1ps

module tag_demux import demux_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              v_i,
   input  tag_t              tag_i,
   input  logic [NUM_CH-1:0] ch_ready_i,
   output logic [NUM_CH-1:0] ch_v_o,
   output logic              yumi_o,
   output drop_cnt_t         drop_cnt_o
);

   logic [NUM_CH-1:0] sel;
   logic              tag_ok;
   logic              drop;
   drop_cnt_t         drop_cnt_q;

   // one-hot decode that is all zero when the tag names no channel
   always_comb
   begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         sel[ch] = (tag_i == TAG_W'(ch));
      end
   end

   assign tag_ok = (tag_i < TAG_W'(NUM_CH));

   // a channel only sees valid when it can take the word
   assign ch_v_o = v_i ? (sel & ch_ready_i) : '0;

   // words with a bad tag are taken at once and thrown away
   assign drop   = v_i & ~tag_ok;
   assign yumi_o = drop | (|ch_v_o);

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         drop_cnt_q <= '0;
      end
      else if (drop && (drop_cnt_q != '1))
      begin
         drop_cnt_q <= drop_cnt_q + 1'b1;
      end
   end

   assign drop_cnt_o = drop_cnt_q;

   // a stalled word must stay offered until it is taken
   a_valid_held : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      v_i && !yumi_o |=> v_i)
      else $error("tag_demux input valid dropped before the word was taken");

   // the tag of a stalled word must not change, or it would be steered elsewhere
   a_tag_held : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      v_i && !yumi_o |=> $stable(tag_i))
      else $error("tag_demux input tag changed before the word was taken");

endmodule

// File: verilog/tagged_demux_fifo.sv
//####################################################################
// splits one tagged stream into NUM_CH channels, each drained on its
// own; bypass channels ignore yumi_i and assume an always-ready sink
//####################################################################
`timescale 1ns/1ps

module tagged_demux_fifo import demux_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   // tagged input stream, held by the source until yumi_o
   input  logic                     v_i,
   input  tag_t                     tag_i,
   input  data_t                    data_i,
   output logic                     yumi_o,

   // one output port per channel
   output logic  [NUM_CH-1:0]       v_o,
   output data_t [NUM_CH-1:0]       data_o,
   input  logic  [NUM_CH-1:0]       yumi_i,

   output drop_cnt_t                drop_cnt_o
);

   logic [NUM_CH-1:0] ch_v;
   logic [NUM_CH-1:0] ch_ready;

   tag_demux u_tag_demux
   (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .v_i        (v_i),
      .tag_i      (tag_i),
      .ch_ready_i (ch_ready),
      .ch_v_o     (ch_v),
      .yumi_o     (yumi_o),
      .drop_cnt_o (drop_cnt_o)
   );

   for (genvar ch = 0; ch < NUM_CH; ch++)
   begin : g_ch
      if (CHAN_KIND[ch] == CHAN_BYPASS)
      begin : g_bypass
         // word leaves in the cycle it is accepted
         assign v_o[ch]      = ch_v[ch];
         assign data_o[ch]   = data_i;
         assign ch_ready[ch] = 1'b1;
      end
      else
      begin : g_buffered
         channel_fifo u_channel_fifo
         (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .v_i      (ch_v[ch]),
            .data_i   (data_i),
            .ready_o  (ch_ready[ch]),
            .v_o      (v_o[ch]),
            .data_o   (data_o[ch]),
            .yumi_i   (yumi_i[ch])
         );
      end
   end

endmodule
